// ==== src.f ====
+incdir+sim
hdl/cpu_pkg.sv
hdl/reg_file.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/mem_stage.sv
hdl/pipe_control.sv
hdl/cpu_top.sv
sim/cpu_tb.sv

// ==== Bender.yml ====
package:
  name: cpu16_pipe

sources:
  - files:
      - hdl/cpu_pkg.sv
      - hdl/reg_file.sv
      - hdl/fetch_stage.sv
      - hdl/decode_stage.sv
      - hdl/execute_stage.sv
      - hdl/mem_stage.sv
      - hdl/pipe_control.sv
      - hdl/cpu_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/cpu_tb.sv

// ==== sim/cpu_tb_model.svh ====
function automatic instr_t r_instr(opcode_t op, reg_sel_t rd, reg_sel_t rs, reg_sel_t rt);
   instr_t ins;
   ins = '0;
   ins.r_fmt.op = op;
   ins.r_fmt.rd = rd;
   ins.r_fmt.rs = rs;
   ins.r_fmt.rt = rt;
   return ins;
endfunction

function automatic instr_t i_instr(opcode_t op, reg_sel_t rd, reg_sel_t rs, int imm);
   instr_t ins;
   ins = '0;
   ins.i_fmt.op  = op;
   ins.i_fmt.rd  = rd;
   ins.i_fmt.rs  = rs;
   ins.i_fmt.imm = imm[5:0];
   return ins;
endfunction

task automatic emit(instr_t ins);
   prog[prog_len] = ins;
   prog_len++;
endtask

// Dependent chain, every result stored
task automatic build_alu_prog();
   prog_len = 0;
   emit(i_instr(OP_ADDI, 3'd1, 3'd0, 5));
   emit(i_instr(OP_ADDI, 3'd2, 3'd1, -3));
   emit(r_instr(OP_ADD, 3'd3, 3'd1, 3'd2));
   emit(r_instr(OP_SUB, 3'd4, 3'd2, 3'd3));
   emit(r_instr(OP_AND, 3'd5, 3'd4, 3'd3));
   emit(r_instr(OP_XOR, 3'd6, 3'd5, 3'd4));
   emit(i_instr(OP_ST, 3'd3, 3'd0, 16));
   emit(i_instr(OP_ST, 3'd4, 3'd0, 17));
   emit(i_instr(OP_ST, 3'd5, 3'd0, 18));
   emit(i_instr(OP_ST, 3'd6, 3'd0, 19));
   emit(i_instr(OP_ST, 3'd2, 3'd1, 20));
   emit(i_instr(OP_HALT, 3'd0, 3'd0, 0));
endtask

// Loads with negative offsets, store then reload of the same word
task automatic build_load_prog();
   prog_len = 0;
   emit(i_instr(OP_LD, 3'd1, 3'd0, 8));
   emit(i_instr(OP_ADDI, 3'd2, 3'd0, 12));
   emit(i_instr(OP_LD, 3'd3, 3'd2, -2));
   emit(r_instr(OP_ADD, 3'd4, 3'd1, 3'd3));
   emit(i_instr(OP_ST, 3'd4, 3'd2, -4));
   emit(i_instr(OP_LD, 3'd5, 3'd2, -4));
   emit(r_instr(OP_ADD, 3'd6, 3'd5, 3'd5));
   emit(i_instr(OP_ST, 3'd6, 3'd0, 30));
   emit(i_instr(OP_HALT, 3'd0, 3'd0, 0));
endtask

// Stores at 41..45 sit in taken branch shadows or are jumped over
task automatic build_branch_prog();
   prog_len = 0;
   emit(i_instr(OP_ADDI, 3'd1, 3'd0, 1));
   emit(i_instr(OP_BEQZ, 3'd0, 3'd1, 5));
   emit(i_instr(OP_ST, 3'd1, 3'd0, 40));
   emit(i_instr(OP_BNEZ, 3'd0, 3'd1, 3));
   emit(i_instr(OP_ST, 3'd1, 3'd0, 41));
   emit(i_instr(OP_ST, 3'd1, 3'd0, 42));
   emit(i_instr(OP_ST, 3'd1, 3'd0, 43));
   emit(i_instr(OP_BEQZ, 3'd0, 3'd0, 3));
   emit(i_instr(OP_ST, 3'd1, 3'd0, 44));
   emit(i_instr(OP_ST, 3'd1, 3'd0, 45));
   emit(i_instr(OP_HALT, 3'd0, 3'd0, 0));
   emit(i_instr(OP_BNEZ, 3'd0, 3'd0, 2));
   // Countdown loop, backward branch
   emit(i_instr(OP_ADDI, 3'd3, 3'd0, 3));
   emit(i_instr(OP_ST, 3'd3, 3'd3, 48));
   emit(i_instr(OP_ADDI, 3'd3, 3'd3, -1));
   emit(i_instr(OP_BNEZ, 3'd0, 3'd3, -3));
   emit(i_instr(OP_ST, 3'd1, 3'd0, 46));
   emit(i_instr(OP_HALT, 3'd0, 3'd0, 0));
endtask

// Runs prog in order and queues every bus request it makes
task automatic run_model();
   word_t     rf [8];
   word_t     pc;
   word_t     addr;
   word_t     simm;
   instr_t    ins;
   dmem_req_t req;
   int        u;
   int        steps;
   bit        done;
   rf    = '{default: '0};
   pc    = '0;
   steps = 0;
   done  = 1'b0;
   while (!done && steps < MODEL_STEP_LIMIT) begin
      ins = prog[pc[7:0]];
      // Low six bits as a two's complement offset
      u = ins[5:0];
      if (u >= 32) begin
         u = u - 64;
      end
      simm = word_t'(u);
      addr = rf[ins.i_fmt.rs] + simm;
      pc   = pc + 16'd1;
      case (ins.r_fmt.op)
         OP_HALT: done = 1'b1;
         OP_ADD:  rf[ins.r_fmt.rd] = rf[ins.r_fmt.rs] + rf[ins.r_fmt.rt];
         OP_SUB:  rf[ins.r_fmt.rd] = rf[ins.r_fmt.rs] - rf[ins.r_fmt.rt];
         OP_AND:  rf[ins.r_fmt.rd] = rf[ins.r_fmt.rs] & rf[ins.r_fmt.rt];
         OP_XOR:  rf[ins.r_fmt.rd] = rf[ins.r_fmt.rs] ^ rf[ins.r_fmt.rt];
         OP_ADDI: rf[ins.i_fmt.rd] = addr;
         OP_LD: begin
            req = '{we: 1'b0, addr: addr, wdata: '0};
            exp_q.push_back(req);
            rf[ins.i_fmt.rd] = mdl_mem[addr[7:0]];
         end
         // Store data comes from rd
         OP_ST: begin
            req = '{we: 1'b1, addr: addr, wdata: rf[ins.i_fmt.rd]};
            exp_q.push_back(req);
            mdl_mem[addr[7:0]] = rf[ins.i_fmt.rd];
         end
         OP_BEQZ: if (rf[ins.i_fmt.rs] == '0) pc = pc + simm;
         OP_BNEZ: if (rf[ins.i_fmt.rs] != '0) pc = pc + simm;
         default: ;
      endcase
      rf[0] = '0;
      steps++;
   end
   if (!done) begin
      fail_with("Reference model never reached a HALT");
   end
endtask

// ==== sim/cpu_tb.sv ====
module cpu_tb import cpu_pkg::*; ();

   localparam int CLK_PERIOD       = 8;
   localparam int N_TESTS          = 5;
   localparam int CYCLES_PER_TEST  = 200;
   localparam int MODEL_STEP_LIMIT = 1000;
   localparam int DMEM_WORDS       = 256;

   logic      clk;
   logic      rst_n;
   imem_wr_t  imem_wr;
   logic      imem_wr_valid;
   logic      start;
   dmem_req_t dmem_req;
   logic      dmem_valid;
   logic      dmem_ready;
   word_t     dmem_rdata;
   logic      halted;

   // Program image, memories, expected requests
   instr_t    prog [IMEM_DEPTH];
   int        prog_len;
   word_t     dmem [DMEM_WORDS];
   word_t     mdl_mem [DMEM_WORDS];
   dmem_req_t exp_q [$];

   string     test_name;
   integer    seed;
   integer    rnd;
   logic      rand_ready;
   logic      req_pending;
   dmem_req_t held_req;
   int        wait_cycles;

   cpu_top dut0 (
      .clk           (clk),
      .rst_n         (rst_n),
      .imem_wr       (imem_wr),
      .imem_wr_valid (imem_wr_valid),
      .start         (start),
      .dmem_req      (dmem_req),
      .dmem_valid    (dmem_valid),
      .dmem_ready    (dmem_ready),
      .dmem_rdata    (dmem_rdata),
      .halted        (halted)
   );

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic stop_run();
      $display("ERRORS FOUND");
      $fatal(1, "Simulation stopped at the first failure");
   endtask

   task automatic fail_with(string msg);
      $display("%s (test %s)", msg, test_name);
      stop_run();
   endtask

   // Load requests carry no meaningful write data
   task automatic check_req(string name, dmem_req_t exp, dmem_req_t act);
      if (act.we !== exp.we || act.addr !== exp.addr ||
          (exp.we && act.wdata !== exp.wdata)) begin
         $display("[ERROR] %s: expected we=%0b addr=%h wdata=%h, actual we=%0b addr=%h wdata=%h",
                  name, exp.we, exp.addr, exp.wdata, act.we, act.addr, act.wdata);
         stop_run();
      end
   endtask

   task automatic check_halt(string name, logic exp, logic act);
      if (act !== exp) begin
         $display("[ERROR] %s: expected halted=%0b, actual halted=%0b", name, exp, act);
         stop_run();
      end
   endtask

   `include "cpu_tb_model.svh"

   // Memory read answers in the same cycle
   assign dmem_rdata = dmem[dmem_req.addr[7:0]];

   always @(posedge clk) begin
      if (rand_ready) begin
         rnd = $random(seed);
         dmem_ready <= rnd[0];
      end else begin
         dmem_ready <= 1'b1;
      end
   end

   // Bus monitor, sampled mid-cycle
   always @(negedge clk) begin
      if (rst_n) begin
         // A waiting request must not move
         if (req_pending && !dmem_valid) begin
            fail_with("Request was dropped before ready");
         end else if (req_pending) begin
            check_req({test_name, " held request"}, held_req, dmem_req);
         end
         req_pending = dmem_valid && !dmem_ready;
         held_req    = dmem_req;
         if (req_pending) begin
            wait_cycles++;
         end
         if (dmem_valid && dmem_ready && exp_q.size() == 0) begin
            fail_with("Bus request appeared that the program never makes");
         end else if (dmem_valid && dmem_ready) begin
            check_req(test_name, exp_q.pop_front(), dmem_req);
            if (dmem_req.we) begin
               dmem[dmem_req.addr[7:0]] = dmem_req.wdata;
            end
         end
      end
   end

   // Pattern spreads all address bits over the word
   function automatic word_t fill_word(int a);
      return {a[7:0] ^ 8'h5a, ~a[7:0]};
   endfunction

   task automatic preload_memory();
      for (int a = 0; a < DMEM_WORDS; a++) begin
         dmem[a]    = fill_word(a);
         mdl_mem[a] = fill_word(a);
      end
   endtask

   task automatic load_program();
      for (int i = 0; i < prog_len; i++) begin
         @(posedge clk);
         imem_wr       <= '{addr: i[7:0], instr: prog[i]};
         imem_wr_valid <= 1'b1;
      end
      @(posedge clk);
      imem_wr_valid <= 1'b0;
   endtask

   // Load, start, wait for halt, then look for stray requests
   task automatic run_program(string name);
      test_name = name;
      exp_q.delete();
      preload_memory();
      run_model();
      load_program();
      @(posedge clk);
      start <= 1'b1;
      @(posedge clk);
      start <= 1'b0;
      do @(negedge clk); while (!halted);
      repeat (10) @(negedge clk);
      if (exp_q.size() != 0) begin
         fail_with($sformatf("%0d expected requests never appeared", exp_q.size()));
      end
      check_halt(name, 1'b1, halted);
   endtask

   task automatic idle_after_reset();
      test_name = "reset";
      if (dmem_valid !== 1'b0) begin
         fail_with("dmem_valid is high after reset");
      end
      check_halt("reset", 1'b0, halted);
      prog_len = 0;
      emit(i_instr(OP_HALT, 3'd0, 3'd0, 0));
      run_program("halt only");
   endtask

   task automatic alu_hazards();
      build_alu_prog();
      run_program("alu chain");
   endtask

   task automatic load_and_negative_imm();
      build_load_prog();
      run_program("load use");
   endtask

   task automatic branch_shadows();
      build_branch_prog();
      run_program("branches");
   endtask

   task automatic ready_back_pressure();
      build_alu_prog();
      wait_cycles = 0;
      rand_ready  = 1'b1;
      run_program("back pressure");
      rand_ready  = 1'b0;
      if (wait_cycles == 0) begin
         fail_with("dmem_ready never held off a request");
      end
   endtask

   initial begin
      #(N_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
      fail_with("Timeout, the processor never halted");
   end

   initial begin
      seed          = 3;
      rand_ready    = 1'b0;
      req_pending   = 1'b0;
      held_req      = '0;
      wait_cycles   = 0;
      test_name     = "reset";
      rst_n         = 1'b0;
      start         = 1'b0;
      imem_wr       = '0;
      imem_wr_valid = 1'b0;
      dmem_ready    = 1'b1;
      repeat (5) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      idle_after_reset();
      alu_hazards();
      load_and_negative_imm();
      branch_shadows();
      ready_back_pressure();
      $display("NO ERRORS");
      $finish;
   end

endmodule

// ==== hdl/cpu_top.sv ====
module cpu_top import cpu_pkg::*; (
   input  logic      clk,
   input  logic      rst_n,
   input  imem_wr_t  imem_wr,
   input  logic      imem_wr_valid,
   input  logic      start,
   output dmem_req_t dmem_req,
   output logic      dmem_valid,
   input  logic      dmem_ready,
   input  word_t     dmem_rdata,
   output logic      halted
);

   // IF/ID
   instr_t     id_instr;
   word_t      id_pc_inc;

   // Decode and register file
   reg_sel_t   rs_sel;
   reg_sel_t   rt_sel;
   word_t      rs_val;
   word_t      rt_val;
   logic [1:0] id_src_used;
   ex_ctrl_t   ex_ctrl;

   // Execute
   logic       branch_taken;
   word_t      branch_target;
   reg_sel_t   ex_dest;
   logic       ex_dest_we;
   mem_ctrl_t  mem_ctrl;

   // Memory and write-back
   reg_sel_t   mem_dest;
   logic       mem_dest_we;
   wb_t        wb;
   logic       wb_halt;

   // Pipeline control
   logic       run;
   logic       stall_id;
   logic       freeze;
   logic       flush;

   fetch_stage u_fetch (
      .clk           (clk),
      .rst_n         (rst_n),
      .imem_wr       (imem_wr),
      .imem_wr_valid (imem_wr_valid),
      .run           (run),
      .start         (start),
      .stall_id      (stall_id),
      .freeze        (freeze),
      .flush         (flush),
      .branch_target (branch_target),
      .id_instr      (id_instr),
      .id_pc_inc     (id_pc_inc)
   );

   decode_stage u_decode (
      .clk         (clk),
      .rst_n       (rst_n),
      .id_instr    (id_instr),
      .id_pc_inc   (id_pc_inc),
      .rs_sel      (rs_sel),
      .rt_sel      (rt_sel),
      .rs_val      (rs_val),
      .rt_val      (rt_val),
      .stall_id    (stall_id),
      .freeze      (freeze),
      .flush       (flush),
      .id_src_used (id_src_used),
      .ex_ctrl     (ex_ctrl)
   );

   // Read in ID, written from WB
   reg_file u_rf (
      .clk    (clk),
      .rst_n  (rst_n),
      .rs_sel (rs_sel),
      .rt_sel (rt_sel),
      .rs_val (rs_val),
      .rt_val (rt_val),
      .wb     (wb)
   );

   execute_stage u_execute (
      .clk           (clk),
      .rst_n         (rst_n),
      .ex_ctrl       (ex_ctrl),
      .freeze        (freeze),
      .flush         (flush),
      .branch_taken  (branch_taken),
      .branch_target (branch_target),
      .ex_dest       (ex_dest),
      .ex_dest_we    (ex_dest_we),
      .mem_ctrl      (mem_ctrl)
   );

   mem_stage u_mem (
      .clk         (clk),
      .rst_n       (rst_n),
      .mem_ctrl    (mem_ctrl),
      .dmem_req    (dmem_req),
      .dmem_valid  (dmem_valid),
      .dmem_ready  (dmem_ready),
      .dmem_rdata  (dmem_rdata),
      .freeze      (freeze),
      .mem_dest    (mem_dest),
      .mem_dest_we (mem_dest_we),
      .wb          (wb),
      .wb_halt     (wb_halt)
   );

   // Index 0 is rs, index 1 is rt
   pipe_control u_ctrl (
      .clk          (clk),
      .rst_n        (rst_n),
      .start        (start),
      .id_srcs      ({rt_sel, rs_sel}),
      .id_src_used  (id_src_used),
      .ex_dest      (ex_dest),
      .ex_dest_we   (ex_dest_we),
      .mem_dest     (mem_dest),
      .mem_dest_we  (mem_dest_we),
      .wb           (wb),
      .dmem_valid   (dmem_valid),
      .dmem_ready   (dmem_ready),
      .branch_taken (branch_taken),
      .wb_halt      (wb_halt),
      .run          (run),
      .stall_id     (stall_id),
      .freeze       (freeze),
      .flush        (flush),
      .halted       (halted)
   );

endmodule

// ==== hdl/pipe_control.sv ====
module pipe_control import cpu_pkg::*; (
   input  logic           clk,
   input  logic           rst_n,
   input  logic           start,
   input  reg_sel_t [1:0] id_srcs,
   input  logic     [1:0] id_src_used,
   input  reg_sel_t       ex_dest,
   input  logic           ex_dest_we,
   input  reg_sel_t       mem_dest,
   input  logic           mem_dest_we,
   input  wb_t            wb,
   input  logic           dmem_valid,
   input  logic           dmem_ready,
   input  logic           branch_taken,
   input  logic           wb_halt,
   output logic           run,
   output logic           stall_id,
   output logic           freeze,
   output logic           flush,
   output logic           halted
);

   run_state_t state;
   logic       hazard;
   logic       start_go;

   // Idle until start, run until HALT retires
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= ST_IDLE;
      end else begin
         case (state)
            ST_IDLE:   if (start) state <= ST_RUN;
            ST_RUN:    if (wb_halt) state <= ST_HALTED;
            ST_HALTED: if (start) state <= ST_RUN;
            default:   state <= ST_IDLE;
         endcase
      end
   end

   assign run      = (state == ST_RUN);
   assign halted   = (state == ST_HALTED);
   assign start_go = start && !run;

   // Source in ID matches any writer still in flight
   always_comb begin
      hazard = 1'b0;
      for (int i = 0; i < 2; i++) begin
         if (id_src_used[i] && (id_srcs[i] != 3'd0)) begin
            hazard |= (ex_dest_we  && (id_srcs[i] == ex_dest)) ||
                      (mem_dest_we && (id_srcs[i] == mem_dest)) ||
                      (wb.we       && (id_srcs[i] == wb.dest));
         end
      end
   end

   // Bus back-pressure wins over everything
   assign freeze   = dmem_valid && !dmem_ready;
   assign stall_id = hazard && !freeze;
   // Start also clears the front of the pipe
   assign flush    = !freeze && (branch_taken || start_go);

endmodule

// ==== hdl/mem_stage.sv ====
module mem_stage import cpu_pkg::*; (
   input  logic      clk,
   input  logic      rst_n,
   input  mem_ctrl_t mem_ctrl,
   output dmem_req_t dmem_req,
   output logic      dmem_valid,
   input  logic      dmem_ready,
   input  word_t     dmem_rdata,
   input  logic      freeze,
   output reg_sel_t  mem_dest,
   output logic      mem_dest_we,
   output wb_t       wb,
   output logic      wb_halt
);

   word_t wb_data;

   // Request straight from EX/MEM, held there by freeze
   assign dmem_valid = mem_ctrl.is_load | mem_ctrl.is_store;
   assign dmem_req   = '{we: mem_ctrl.is_store, addr: mem_ctrl.result,
                         wdata: mem_ctrl.st_data};

   assign mem_dest    = mem_ctrl.dest;
   assign mem_dest_we = mem_ctrl.dest_we;

   // Write-back select
   // Load data is only valid in the handshake cycle
   assign wb_data = (mem_ctrl.is_load && dmem_ready) ? dmem_rdata : mem_ctrl.result;

   // MEM/WB register
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wb      <= WB_NOP;
         wb_halt <= 1'b0;
      end else if (!freeze) begin
         wb      <= '{dest: mem_ctrl.dest, we: mem_ctrl.dest_we, data: wb_data};
         wb_halt <= mem_ctrl.is_halt;
      end
   end

endmodule

// ==== hdl/execute_stage.sv ====
module execute_stage import cpu_pkg::*; (
   input  logic      clk,
   input  logic      rst_n,
   input  ex_ctrl_t  ex_ctrl,
   input  logic      freeze,
   input  logic      flush,
   output logic      branch_taken,
   output word_t     branch_target,
   output reg_sel_t  ex_dest,
   output logic      ex_dest_we,
   output mem_ctrl_t mem_ctrl
);

   word_t result;

   // ALU and branch decision
   always_comb begin
      result       = '0;
      branch_taken = 1'b0;
      case (ex_ctrl.op)
         OP_ADD:  result = ex_ctrl.rs_val + ex_ctrl.rt_val;
         OP_SUB:  result = ex_ctrl.rs_val - ex_ctrl.rt_val;
         OP_AND:  result = ex_ctrl.rs_val & ex_ctrl.rt_val;
         OP_XOR:  result = ex_ctrl.rs_val ^ ex_ctrl.rt_val;
         // Immediate add and address generation
         OP_ADDI, OP_LD, OP_ST: result = ex_ctrl.rs_val + ex_ctrl.imm;
         OP_BEQZ: branch_taken = (ex_ctrl.rs_val == '0);
         OP_BNEZ: branch_taken = (ex_ctrl.rs_val != '0);
         default: result = '0;
      endcase
   end

   // Relative to PC plus one
   assign branch_target = ex_ctrl.pc_inc + ex_ctrl.imm;

   // Pending destination for hazard check
   assign ex_dest    = ex_ctrl.dest;
   assign ex_dest_we = ex_ctrl.dest_we;

   // EX/MEM register
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         mem_ctrl <= MEM_NOP;
      end else if (!freeze) begin
         if (flush && !branch_taken) begin
            // Flush from start, not from this branch
            mem_ctrl <= MEM_NOP;
         end else begin
            mem_ctrl <= '{is_load: ex_ctrl.op == OP_LD, is_store: ex_ctrl.op == OP_ST,
                          is_halt: ex_ctrl.op == OP_HALT, dest: ex_ctrl.dest,
                          dest_we: ex_ctrl.dest_we, result: result,
                          st_data: ex_ctrl.rt_val};
         end
      end
   end

endmodule

// ==== hdl/decode_stage.sv ====
module decode_stage import cpu_pkg::*; (
   input  logic       clk,
   input  logic       rst_n,
   input  instr_t     id_instr,
   input  word_t      id_pc_inc,
   output reg_sel_t   rs_sel,
   output reg_sel_t   rt_sel,
   input  word_t      rs_val,
   input  word_t      rt_val,
   input  logic       stall_id,
   input  logic       freeze,
   input  logic       flush,
   output logic [1:0] id_src_used,
   output ex_ctrl_t   ex_ctrl
);

   opcode_t  op;
   reg_sel_t dest;
   logic     dest_we;
   word_t    imm_ext;

   assign op      = id_instr.r_fmt.op;
   // Sign extend the 6-bit immediate
   assign imm_ext = {{10{id_instr.i_fmt.imm[5]}}, id_instr.i_fmt.imm};

   // Source selects, source usage, destination
   // id_src_used bit 0 is rs, bit 1 is rt
   always_comb begin
      rs_sel      = id_instr.r_fmt.rs;
      rt_sel      = id_instr.r_fmt.rt;
      dest        = id_instr.r_fmt.rd;
      dest_we     = 1'b0;
      id_src_used = 2'b00;
      case (op)
         OP_ADD, OP_SUB, OP_AND, OP_XOR: begin
            id_src_used = 2'b11;
            dest_we     = 1'b1;
         end
         OP_ADDI, OP_LD: begin
            id_src_used = 2'b01;
            dest_we     = 1'b1;
         end
         // rd is a source here, nothing is written
         OP_ST: begin
            rt_sel      = id_instr.i_fmt.rd;
            id_src_used = 2'b11;
         end
         OP_BEQZ, OP_BNEZ: begin
            rt_sel      = id_instr.i_fmt.rd;
            id_src_used = 2'b01;
         end
         default: begin
            id_src_used = 2'b00;
         end
      endcase
   end

   // ID/EX register
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ex_ctrl <= EX_NOP;
      end else if (!freeze) begin
         if (stall_id || flush) begin
            // Bubble into EX
            ex_ctrl <= EX_NOP;
         end else begin
            ex_ctrl <= '{op: op, dest: dest, dest_we: dest_we, rs_val: rs_val,
                         rt_val: rt_val, imm: imm_ext, pc_inc: id_pc_inc};
         end
      end
   end

endmodule

// ==== hdl/fetch_stage.sv ====
module fetch_stage import cpu_pkg::*; (
   input  logic     clk,
   input  logic     rst_n,
   input  imem_wr_t imem_wr,
   input  logic     imem_wr_valid,
   input  logic     run,
   input  logic     start,
   input  logic     stall_id,
   input  logic     freeze,
   input  logic     flush,
   input  word_t    branch_target,
   output instr_t   id_instr,
   output word_t    id_pc_inc
);

   instr_t imem [IMEM_DEPTH];
   word_t  pc;
   word_t  pc_inc;
   word_t  pc_next;
   instr_t if_instr;

   // Program load, only while not running
   always_ff @(posedge clk) begin
      if (imem_wr_valid && !run) begin
         imem[imem_wr.addr] <= imem_wr.instr;
      end
   end

   assign if_instr = imem[pc[IMEM_AW-1:0]];
   assign pc_inc   = pc + 16'd1;
   // PC parks on a HALT so nothing past it gets fetched
   assign pc_next  = (if_instr.r_fmt.op == OP_HALT) ? pc : pc_inc;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pc        <= '0;
         id_instr  <= NOP_INSTR;
         id_pc_inc <= '0;
      end else if (start && !run) begin
         // Start restarts from word 0
         pc       <= '0;
         id_instr <= NOP_INSTR;
      end else if (!freeze) begin
         if (flush) begin
            // Kill the shadow slot, redirect
            pc       <= branch_target;
            id_instr <= NOP_INSTR;
         end else if (!run) begin
            id_instr <= NOP_INSTR;
         end else if (!stall_id) begin
            pc        <= pc_next;
            id_instr  <= if_instr;
            id_pc_inc <= pc_inc;
         end
      end
   end

endmodule

// ==== hdl/reg_file.sv ====
module reg_file import cpu_pkg::*; (
   input  logic     clk,
   input  logic     rst_n,
   input  reg_sel_t rs_sel,
   input  reg_sel_t rt_sel,
   output word_t    rs_val,
   output word_t    rt_val,
   input  wb_t      wb
);

   word_t regs [8];

   // Write at end of WB, r0 never written
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         regs <= '{default: '0};
      end else if (wb.we && (wb.dest != 3'd0)) begin
         regs[wb.dest] <= wb.data;
      end
   end

   // Reads are combinational, no bypass
   assign rs_val = regs[rs_sel];
   assign rt_val = regs[rt_sel];

endmodule

// ==== hdl/cpu_pkg.sv ====
package cpu_pkg;

   // Data and address word
   typedef logic [15:0] word_t;
   typedef logic [2:0]  reg_sel_t;

   // Opcode lives in the top nibble
   typedef enum logic [3:0] {
      OP_HALT = 4'h0,
      OP_NOP  = 4'h1,
      OP_ADD  = 4'h2,
      OP_SUB  = 4'h3,
      OP_AND  = 4'h4,
      OP_XOR  = 4'h5,
      OP_ADDI = 4'h6,
      OP_LD   = 4'h7,
      OP_ST   = 4'h8,
      OP_BEQZ = 4'h9,
      OP_BNEZ = 4'ha
   } opcode_t;

   // Instruction memory size in words
   localparam int IMEM_DEPTH = 256;
   localparam int IMEM_AW    = $clog2(IMEM_DEPTH);

   // Register and immediate views of one word
   typedef union packed {
      struct packed {
         opcode_t    op;
         reg_sel_t   rd;
         reg_sel_t   rs;
         reg_sel_t   rt;
         logic [2:0] pad;
      } r_fmt;
      struct packed {
         opcode_t           op;
         reg_sel_t          rd;
         reg_sel_t          rs;
         logic signed [5:0] imm;
      } i_fmt;
   } instr_t;

   // Bubble word for flushed or stalled slots
   localparam instr_t NOP_INSTR = instr_t'({OP_NOP, 12'h000});

   typedef struct packed {
      logic [IMEM_AW-1:0] addr;
      instr_t             instr;
   } imem_wr_t;

   typedef struct packed {
      logic  we;
      word_t addr;
      word_t wdata;
   } dmem_req_t;

   // ID/EX contents
   typedef struct packed {
      opcode_t  op;
      reg_sel_t dest;
      logic     dest_we;
      word_t    rs_val;
      word_t    rt_val;
      word_t    imm;
      word_t    pc_inc;
   } ex_ctrl_t;

   // EX/MEM contents
   typedef struct packed {
      logic     is_load;
      logic     is_store;
      logic     is_halt;
      reg_sel_t dest;
      logic     dest_we;
      word_t    result;
      word_t    st_data;
   } mem_ctrl_t;

   // MEM/WB contents, also the register file write
   typedef struct packed {
      reg_sel_t dest;
      logic     we;
      word_t    data;
   } wb_t;

   // Bubbles for each pipeline register
   localparam ex_ctrl_t  EX_NOP  = '{op: OP_NOP, default: '0};
   localparam mem_ctrl_t MEM_NOP = '0;
   localparam wb_t       WB_NOP  = '0;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_RUN,
      ST_HALTED
   } run_state_t;

endpackage
